// ==== hw/mm_params.svh ====
/*
 * Montgomery multiplier parameters
 * Word size, word count, AXI4-Lite widths and register map
 */
`ifndef MM_PARAMS_SVH
`define MM_PARAMS_SVH

// Datapath sizing
`define MM_RADIX        16
`define MM_WORDS        4
`define MM_WIDTH        (`MM_RADIX * `MM_WORDS)

// AXI4-Lite bus widths
`define MM_AXI_ADDR_W   8
`define MM_AXI_DATA_W   32

// Register map, 64-bit operands take two words at base and base + 4
`define MM_REG_CTRL     8'h00
`define MM_REG_STATUS   8'h04
`define MM_REG_NPRIME   8'h08
`define MM_REG_A        8'h10
`define MM_REG_B        8'h18
`define MM_REG_P        8'h20
`define MM_REG_R        8'h28

`endif

// ==== hw/mm_pkg.sv ====
/*
 * Montgomery multiplier types
 * Operand bundle, raw result and status flags shared across the design
 */
`include "mm_params.svh"

package mm_pkg;

    // ------------------------------------------------------------------------
    // Operand bundle from the register block
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic [`MM_WIDTH-1:0] a;
        logic [`MM_WIDTH-1:0] b;
        logic [`MM_WIDTH-1:0] p;
        // Negated inverse of p modulo 2^radix
        logic [`MM_RADIX-1:0] nprime;
    } mm_operands_t;

    // ------------------------------------------------------------------------
    // Core output before the final subtraction
    // ------------------------------------------------------------------------
    typedef struct packed {
        // Carry out of the top word
        logic                 overflow;
        logic [`MM_WIDTH-1:0] r;
    } mm_result_t;

    // Status register bits
    typedef struct packed {
        logic done;
        logic busy;
    } mm_status_t;

endpackage

// ==== hw/mm_pe.sv ====
/*
 * Montgomery processing element
 * Forms a*b + m*p + carry + sum for one word and registers sum and carry
 */
`timescale 1ns/1ps
`include "mm_params.svh"

module mm_pe (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 clear,
    input  logic                 odd,
    input  logic [`MM_RADIX-1:0] a_word,
    input  logic [`MM_RADIX-1:0] b_word,
    input  logic [`MM_RADIX-1:0] p_word,
    input  logic [`MM_RADIX-1:0] m_word,
    input  logic [`MM_RADIX-1:0] s_in,
    input  logic [`MM_RADIX:0]   c_in,
    output logic [`MM_RADIX-1:0] a_out,
    output logic [`MM_RADIX-1:0] m_out,
    output logic [`MM_RADIX-1:0] s_out,
    output logic [`MM_RADIX:0]   c_out
);

    localparam int R = `MM_RADIX;

    logic [2*R-1:0] prod_ab;
    logic [2*R-1:0] prod_mp;
    logic [R:0]     c_sel;
    logic [R-1:0]   s_sel;
    logic [2*R:0]   acc;

    // Two word multipliers
    assign prod_ab = a_word * b_word;
    assign prod_mp = m_word * p_word;

    // Odd phase keeps its own carry and takes the upper neighbour's sum,
    // which shifts the running sum down one word
    assign c_sel = odd ? c_out : c_in;
    assign s_sel = odd ? s_in : s_out;

    // Fits in 2R+1 bits for any word values
    assign acc = (2*R+1)'(prod_ab) + (2*R+1)'(prod_mp) + (2*R+1)'(c_sel) + (2*R+1)'(s_sel);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            s_out <= '0;
            c_out <= '0;
            a_out <= '0;
            m_out <= '0;
        end else if (clear) begin
            s_out <= '0;
            c_out <= '0;
            a_out <= '0;
            m_out <= '0;
        end else begin
            s_out <= acc[R-1:0];
            c_out <= acc[2*R:R];
            // Forward a and m to the next element
            if (odd) begin
                a_out <= a_word;
                m_out <= m_word;
            end
        end
    end

endmodule

// ==== hw/mm_core.sv ====
/*
 * Montgomery multiplier core
 * Word-serial CIOS controller driving a row of processing elements
 */
`timescale 1ns/1ps
`include "mm_params.svh"

module mm_core (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 start,
    input  mm_pkg::mm_operands_t operands,
    output logic                 busy,
    output mm_pkg::mm_result_t   result,
    output logic                 result_valid
);

    localparam int R = `MM_RADIX;
    localparam int W = `MM_WORDS;
    localparam int ACC_W = `MM_WIDTH + R + 1;

    typedef enum logic [1:0] {ST_IDLE, ST_CLR, ST_RUN, ST_FIN} state_t;

    state_t state;
    logic [$clog2(W+1)-1:0] cnt;

    // Operands captured at start
    // Software may rewrite the registers while busy
    logic [`MM_WIDTH-1:0] a_q;
    logic [`MM_WIDTH-1:0] b_q;
    logic [`MM_WIDTH-1:0] p_q;
    logic [R-1:0]         nprime_q;

    logic [R-1:0] a_i;
    logic [R-1:0] m_i;
    logic [2*R:0] u0;
    logic [2*R-1:0] m_full;
    logic [R-1:0] s_row [W];
    logic [R:0]   c_row [W];
    logic [R-1:0] s_nb  [W];
    logic [R:0]   c_nb  [W];
    logic [ACC_W-1:0] fold;

    assign busy = (state != ST_IDLE);
    assign a_i  = a_q[cnt*R +: R];

    // Neighbour links
    // The top element sees a zero sum
    always_comb begin
        for (int j = 0; j < W; j++) begin
            s_nb[j] = (j == W-1) ? '0 : s_row[(j+1) % W];
            c_nb[j] = (j == 0) ? '0 : c_row[(j+W-1) % W];
        end
    end

    // m makes the low word of element 0 vanish
    assign u0     = (2*R+1)'(a_i * b_q[R-1:0]) + (2*R+1)'(s_nb[0]) + (2*R+1)'(c_row[0]);
    assign m_full = u0[R-1:0] * nprime_q;
    assign m_i    = m_full[R-1:0];

    for (genvar j = 0; j < W; j++) begin : g_pe
        mm_pe i_pe (
            .clk     (clk),
            .reset_n (reset_n),
            .clear   (state == ST_CLR),
            .odd     (state == ST_RUN),
            .a_word  (a_i),
            .b_word  (b_q[j*R +: R]),
            .p_word  (p_q[j*R +: R]),
            .m_word  (m_i),
            .s_in    (s_nb[j]),
            .c_in    (c_nb[j]),
            .a_out   (),
            .m_out   (),
            .s_out   (s_row[j]),
            .c_out   (c_row[j])
        );
    end

    // Resolve the carry-save row into one word, shifted down by one word
    always_comb begin
        fold = '0;
        for (int j = 0; j < W; j++) begin
            fold = fold + (ACC_W'(s_row[j]) << (R*j)) + (ACC_W'(c_row[j]) << (R*(j+1)));
        end
    end

    // Operand capture
    always_ff @(posedge clk) begin
        if (start && !busy) begin
            a_q      <= operands.a;
            b_q      <= operands.b;
            p_q      <= operands.p;
            nprime_q <= operands.nprime;
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_FIN) begin
            result <= fold[ACC_W-1:R];
        end
    end

    // Iteration FSM with one cycle per word of a
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state        <= ST_IDLE;
            cnt          <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= 1'b0;
            case (state)
                ST_IDLE: if (start) state <= ST_CLR;
                ST_CLR: begin
                    cnt   <= '0;
                    state <= ST_RUN;
                end
                ST_RUN: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == W-1) state <= ST_FIN;
                end
                default: begin
                    result_valid <= 1'b1;
                    state        <= ST_IDLE;
                end
            endcase
        end
    end

    // Register block must drop starts during a run
    a_start_idle: assert property (@(posedge clk) disable iff (!reset_n) !(start && busy));
    // A run is one clear cycle, one cycle per word and one finish cycle
    a_run_length: assert property (@(posedge clk) disable iff (!reset_n)
                                   result_valid |-> $past(start, W+3));

endmodule

// ==== hw/mm_final_sub.sv ====
/*
 * Final conditional subtraction
 * Brings the core result below p and holds it in a register
 */
`timescale 1ns/1ps
`include "mm_params.svh"

module mm_final_sub (
    input  logic                 clk,
    input  logic                 reset_n,
    input  mm_pkg::mm_result_t   result,
    input  logic                 result_valid,
    input  logic [`MM_WIDTH-1:0] p,
    output logic [`MM_WIDTH-1:0] product,
    output logic                 product_valid
);

    logic                 need_sub;
    logic [`MM_WIDTH-1:0] diff;

    // Core result is below 2p, one subtraction is enough
    assign need_sub = result.overflow || (result.r >= p);
    assign diff     = result.r - p;

    always_ff @(posedge clk) begin
        if (result_valid) begin
            product <= need_sub ? diff : result.r;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            product_valid <= 1'b0;
        end else begin
            product_valid <= result_valid;
        end
    end

    // Holds only while A and B stay below P
    a_reduced: assert property (@(posedge clk) disable iff (!reset_n) product_valid |-> product < p);

endmodule

// ==== hw/mm_axil_regs.sv ====
/*
 * AXI4-Lite register block
 * Operand, control, status and result registers with start qualification
 */
`timescale 1ns/1ps
`include "mm_params.svh"

module mm_axil_regs (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic [`MM_AXI_ADDR_W-1:0] awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [`MM_AXI_DATA_W-1:0] wdata,
    input  logic [3:0]                wstrb,
    input  logic                      wvalid,
    output logic                      wready,
    output logic [1:0]                bresp,
    output logic                      bvalid,
    input  logic                      bready,
    input  logic [`MM_AXI_ADDR_W-1:0] araddr,
    input  logic                      arvalid,
    output logic                      arready,
    output logic [`MM_AXI_DATA_W-1:0] rdata,
    output logic [1:0]                rresp,
    output logic                      rvalid,
    input  logic                      rready,
    output mm_pkg::mm_operands_t      operands,
    output logic                      start,
    output logic                      done,
    input  mm_pkg::mm_status_t        status,
    input  logic [`MM_WIDTH-1:0]      product,
    input  logic                      product_valid
);

    // ------------------------------------------------------------------------
    // Write channel
    // ------------------------------------------------------------------------
    logic                      aw_full;
    logic                      w_full;
    logic [`MM_AXI_ADDR_W-1:0] aw_q;
    logic [`MM_AXI_DATA_W-1:0] w_q;
    logic                      do_write;
    logic [`MM_WIDTH-1:0]      r_q;

    // Narrow strobes count as full writes
    assign awready  = !aw_full && !bvalid;
    assign wready   = !w_full && !bvalid;
    assign do_write = aw_full && w_full && !bvalid;
    assign bresp    = 2'b00;
    assign rresp    = 2'b00;

    always_ff @(posedge clk) begin
        if (awvalid && awready) aw_q <= awaddr;
        if (wvalid && wready) w_q <= wdata;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            aw_full <= 1'b0;
            w_full  <= 1'b0;
            bvalid  <= 1'b0;
            start   <= 1'b0;
            done    <= 1'b0;
        end else begin
            if (awvalid && awready) aw_full <= 1'b1;
            if (wvalid && wready) w_full <= 1'b1;
            if (do_write) begin
                aw_full <= 1'b0;
                w_full  <= 1'b0;
                bvalid  <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            // Start only when idle, a start during a run is dropped
            start <= do_write && (aw_q == `MM_REG_CTRL) && w_q[0] && !status.busy;
            if (start) done <= 1'b0;
            else if (product_valid) done <= 1'b1;
        end
    end

    // Operand and result storage
    always_ff @(posedge clk) begin
        if (do_write) begin
            case (aw_q)
                `MM_REG_NPRIME:         operands.nprime <= w_q[`MM_RADIX-1:0];
                `MM_REG_A:              operands.a[31:0] <= w_q;
                `MM_REG_A + 8'h04:      operands.a[63:32] <= w_q;
                `MM_REG_B:              operands.b[31:0] <= w_q;
                `MM_REG_B + 8'h04:      operands.b[63:32] <= w_q;
                `MM_REG_P:              operands.p[31:0] <= w_q;
                `MM_REG_P + 8'h04:      operands.p[63:32] <= w_q;
                default: ;
            endcase
        end
        if (product_valid) r_q <= product;
    end

    // ------------------------------------------------------------------------
    // Read channel
    // ------------------------------------------------------------------------
    assign arready = !rvalid;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rvalid <= 1'b0;
        end else if (arvalid && arready) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (arvalid && arready) begin
            case (araddr)
                `MM_REG_STATUS:    rdata <= {30'b0, status.done, status.busy};
                `MM_REG_NPRIME:    rdata <= `MM_AXI_DATA_W'(operands.nprime);
                `MM_REG_A:         rdata <= operands.a[31:0];
                `MM_REG_A + 8'h04: rdata <= operands.a[63:32];
                `MM_REG_B:         rdata <= operands.b[31:0];
                `MM_REG_B + 8'h04: rdata <= operands.b[63:32];
                `MM_REG_P:         rdata <= operands.p[31:0];
                `MM_REG_P + 8'h04: rdata <= operands.p[63:32];
                `MM_REG_R:         rdata <= r_q[31:0];
                `MM_REG_R + 8'h04: rdata <= r_q[63:32];
                // CTRL and unmapped offsets
                default:           rdata <= '0;
            endcase
        end
    end

endmodule

// ==== hw/mm_top.sv ====
/*
 * Montgomery multiplier top level
 * AXI4-Lite register block, CIOS core and final subtraction
 */
`timescale 1ns/1ps
`include "mm_params.svh"

module mm_top (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic [`MM_AXI_ADDR_W-1:0] awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [`MM_AXI_DATA_W-1:0] wdata,
    input  logic [3:0]                wstrb,
    input  logic                      wvalid,
    output logic                      wready,
    output logic [1:0]                bresp,
    output logic                      bvalid,
    input  logic                      bready,
    input  logic [`MM_AXI_ADDR_W-1:0] araddr,
    input  logic                      arvalid,
    output logic                      arready,
    output logic [`MM_AXI_DATA_W-1:0] rdata,
    output logic [1:0]                rresp,
    output logic                      rvalid,
    input  logic                      rready
);

    mm_pkg::mm_operands_t operands;
    mm_pkg::mm_result_t   result;
    mm_pkg::mm_status_t   status;
    logic                 start;
    logic                 busy;
    logic                 done;
    logic                 result_valid;
    logic [`MM_WIDTH-1:0] product;
    logic                 product_valid;

    assign status = '{done: done, busy: busy};

    mm_axil_regs i_regs (
        .clk (clk), .reset_n (reset_n),
        .awaddr (awaddr), .awvalid (awvalid), .awready (awready),
        .wdata (wdata), .wstrb (wstrb), .wvalid (wvalid), .wready (wready),
        .bresp (bresp), .bvalid (bvalid), .bready (bready),
        .araddr (araddr), .arvalid (arvalid), .arready (arready),
        .rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rready (rready),
        .operands (operands), .start (start), .done (done), .status (status),
        .product (product), .product_valid (product_valid)
    );

    mm_core i_core (
        .clk (clk), .reset_n (reset_n), .start (start), .operands (operands),
        .busy (busy), .result (result), .result_valid (result_valid)
    );

    mm_final_sub i_final_sub (
        .clk (clk), .reset_n (reset_n), .result (result), .result_valid (result_valid),
        .p (operands.p), .product (product), .product_valid (product_valid)
    );

endmodule

// ==== verif/tb_mm_top.sv ====
/*
 * Montgomery multiplier testbench
 * Drives mm_top over AXI4-Lite with random and edge operands
 * and checks every result against a wide-arithmetic model
 */
`timescale 1ns/1ps
`include "mm_params.svh"

module tb_mm_top;

    localparam int SEED         = 23888;
    localparam int NUM_TRIALS   = 40;
    // Random trials plus edge, status, busy and back-pressure operations
    localparam int NUM_OPS      = NUM_TRIALS + 12;
    localparam int POLL_BOUND   = 64;
    localparam int AXI_OVERHEAD = 400;
    localparam int MAX_CYCLES   = NUM_OPS * (POLL_BOUND + AXI_OVERHEAD);
    localparam int MAX_POLLS    = 32;

    logic                      clk = 1'b0;
    logic                      reset_n;
    logic [`MM_AXI_ADDR_W-1:0] awaddr;
    logic                      awvalid;
    logic                      awready;
    logic [`MM_AXI_DATA_W-1:0] wdata;
    logic [3:0]                wstrb;
    logic                      wvalid;
    logic                      wready;
    logic [1:0]                bresp;
    logic                      bvalid;
    logic                      bready;
    logic [`MM_AXI_ADDR_W-1:0] araddr;
    logic                      arvalid;
    logic                      arready;
    logic [`MM_AXI_DATA_W-1:0] rdata;
    logic [1:0]                rresp;
    logic                      rvalid;
    logic                      rready;

    int errors = 0;
    int cycles = 0;
    // Upper bound of random response stall cycles
    // Zero means no stall
    int bp_max = 0;

    mm_top i_dut (
        .clk (clk), .reset_n (reset_n),
        .awaddr (awaddr), .awvalid (awvalid), .awready (awready),
        .wdata (wdata), .wstrb (wstrb), .wvalid (wvalid), .wready (wready),
        .bresp (bresp), .bvalid (bvalid), .bready (bready),
        .araddr (araddr), .arvalid (arvalid), .arready (arready),
        .rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rready (rready)
    );

    always #5 clk = ~clk;

    // Run limit
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("Run stopped because it exceeded %0d cycles", MAX_CYCLES);
            $display("Errors: %0d", errors);
            $display("Verification failed");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------
    // Negated inverse of p modulo 2^radix by Newton iteration
    function automatic logic [`MM_RADIX-1:0] nprime_of(input logic [`MM_WIDTH-1:0] p);
        logic [`MM_RADIX-1:0] inv;
        inv = p[`MM_RADIX-1:0];
        // Correct to 3 bits for odd p
        // Precision doubles each step
        for (int i = 0; i < 5; i++) begin
            inv = inv * (`MM_RADIX'(2) - p[`MM_RADIX-1:0] * inv);
        end
        return `MM_RADIX'(0) - inv;
    endfunction

    // a * b * 2^(-width) mod p
    function automatic logic [`MM_WIDTH-1:0] mont_model(input logic [`MM_WIDTH-1:0] a,
                                                        input logic [`MM_WIDTH-1:0] b,
                                                        input logic [`MM_WIDTH-1:0] p);
        logic [`MM_WIDTH:0]     rinv;
        logic [2*`MM_WIDTH-1:0] prod;
        rinv = 1;
        // Halve modulo p once per bit of R
        for (int i = 0; i < `MM_WIDTH; i++) begin
            if (rinv[0]) rinv = (rinv + p) >> 1;
            else rinv = rinv >> 1;
        end
        prod = (2*`MM_WIDTH)'(a) * (2*`MM_WIDTH)'(b);
        prod = prod % (2*`MM_WIDTH)'(p);
        prod = prod * (2*`MM_WIDTH)'(rinv[`MM_WIDTH-1:0]);
        prod = prod % (2*`MM_WIDTH)'(p);
        return prod[`MM_WIDTH-1:0];
    endfunction

    // R^2 mod p with R = 2^width
    function automatic logic [`MM_WIDTH-1:0] r_squared(input logic [`MM_WIDTH-1:0] p);
        logic [2*`MM_WIDTH-1:0] r1;
        r1 = ((2*`MM_WIDTH)'(1) << `MM_WIDTH) % (2*`MM_WIDTH)'(p);
        r1 = (r1 * r1) % (2*`MM_WIDTH)'(p);
        return r1[`MM_WIDTH-1:0];
    endfunction

    function automatic logic [`MM_WIDTH-1:0] rand64();
        return {$urandom(), $urandom()};
    endfunction

    task automatic check(input string name, input logic [`MM_WIDTH-1:0] expected,
                         input logic [`MM_WIDTH-1:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("error %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // ------------------------------------------------------------------------
    // AXI4-Lite driver tasks start and end on a falling edge
    // ------------------------------------------------------------------------
    task automatic axi_write(input logic [`MM_AXI_ADDR_W-1:0] addr,
                             input logic [`MM_AXI_DATA_W-1:0] data);
        logic aw_hs;
        logic w_hs;
        int   hold;
        awaddr  = addr;
        awvalid = 1'b1;
        wdata   = data;
        wvalid  = 1'b1;
        while (awvalid || wvalid) begin
            // Ready is stable until the next rising edge completes the transfer
            aw_hs = awvalid && awready;
            w_hs  = wvalid && wready;
            @(negedge clk);
            if (aw_hs) awvalid = 1'b0;
            if (w_hs) wvalid = 1'b0;
        end
        while (!bvalid) @(negedge clk);
        hold = (bp_max > 0) ? $urandom_range(bp_max, 0) : 0;
        repeat (hold) begin
            @(negedge clk);
            check("bvalid_held", 1, bvalid);
        end
        check("bresp", 0, bresp);
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [`MM_AXI_ADDR_W-1:0] addr,
                            output logic [`MM_AXI_DATA_W-1:0] data);
        logic ar_hs;
        int   hold;
        araddr  = addr;
        arvalid = 1'b1;
        while (arvalid) begin
            ar_hs = arready;
            @(negedge clk);
            if (ar_hs) arvalid = 1'b0;
        end
        while (!rvalid) @(negedge clk);
        data = rdata;
        hold = (bp_max > 0) ? $urandom_range(bp_max, 0) : 0;
        // Stalled response must keep valid and data
        repeat (hold) begin
            @(negedge clk);
            check("rvalid_held", 1, rvalid);
            check("rdata_held", data, rdata);
        end
        check("rresp", 0, rresp);
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic write_wide(input logic [`MM_AXI_ADDR_W-1:0] addr,
                              input logic [`MM_WIDTH-1:0] value);
        axi_write(addr, value[31:0]);
        axi_write(addr + 8'h04, value[63:32]);
    endtask

    task automatic read_wide(input logic [`MM_AXI_ADDR_W-1:0] addr,
                             output logic [`MM_WIDTH-1:0] value);
        logic [`MM_AXI_DATA_W-1:0] lo;
        logic [`MM_AXI_DATA_W-1:0] hi;
        axi_read(addr, lo);
        axi_read(addr + 8'h04, hi);
        value = {hi, lo};
    endtask

    // ------------------------------------------------------------------------
    // Operation helpers
    // ------------------------------------------------------------------------
    task automatic load_operands(input logic [`MM_WIDTH-1:0] a, input logic [`MM_WIDTH-1:0] b,
                                 input logic [`MM_WIDTH-1:0] p);
        write_wide(`MM_REG_A, a);
        write_wide(`MM_REG_B, b);
        write_wide(`MM_REG_P, p);
        axi_write(`MM_REG_NPRIME, `MM_AXI_DATA_W'(nprime_of(p)));
    endtask

    // Poll STATUS until done
    // Busy and done never show together
    task automatic wait_done();
        logic [`MM_AXI_DATA_W-1:0] st;
        int                        polls;
        polls = 1;
        axi_read(`MM_REG_STATUS, st);
        check("status_busy_done", 0, st[0] & st[1]);
        while (!st[1] && polls < MAX_POLLS) begin
            axi_read(`MM_REG_STATUS, st);
            check("status_busy_done", 0, st[0] & st[1]);
            polls++;
        end
        if (!st[1]) begin
            errors++;
            $display("STATUS did not show done within %0d reads", MAX_POLLS);
        end
    endtask

    task automatic run_mult(input string name, input logic [`MM_WIDTH-1:0] a,
                            input logic [`MM_WIDTH-1:0] b, input logic [`MM_WIDTH-1:0] p);
        logic [`MM_WIDTH-1:0] r;
        load_operands(a, b, p);
        axi_write(`MM_REG_CTRL, 32'h1);
        wait_done();
        read_wide(`MM_REG_R, r);
        check(name, mont_model(a, b, p), r);
    endtask

    // ------------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------------
    task automatic register_access();
        logic [`MM_WIDTH-1:0]      v;
        logic [`MM_WIDTH-1:0]      rd;
        logic [`MM_AXI_DATA_W-1:0] word;
        logic [`MM_AXI_ADDR_W-1:0] unmapped [5];
        unmapped = '{8'h0C, 8'h30, 8'h3C, 8'h80, 8'hFC};
        for (int i = 0; i < 3; i++) begin
            v = rand64();
            write_wide(`MM_REG_A + 8'(i * 8), v);
            read_wide(`MM_REG_A + 8'(i * 8), rd);
            check("reg_readback", v, rd);
        end
        word = `MM_AXI_DATA_W'($urandom_range(16'hFFFF, 0));
        axi_write(`MM_REG_NPRIME, word);
        axi_read(`MM_REG_NPRIME, rd[31:0]);
        check("nprime_readback", word, rd[31:0]);
        // Writes to unmapped offsets vanish
        foreach (unmapped[i]) begin
            axi_write(unmapped[i], $urandom());
            axi_read(unmapped[i], word);
            check("unmapped_zero", 0, word);
        end
    endtask

    task automatic random_mults();
        logic [`MM_WIDTH-1:0] p;
        for (int t = 0; t < NUM_TRIALS; t++) begin
            p = rand64() | `MM_WIDTH'(1);
            run_mult("random_mult", rand64() % p, rand64() % p, p);
        end
    endtask

    task automatic edge_operands();
        logic [`MM_WIDTH-1:0] p;
        p = rand64() | `MM_WIDTH'(1);
        run_mult("a_zero", 0, rand64() % p, p);
        run_mult("b_zero", rand64() % p, 0, p);
        run_mult("one_times_r2", 1, r_squared(p), p);
        // Largest modulus drives the carry out of the top word
        p = {`MM_WIDTH{1'b1}};
        run_mult("overflow_max_p", rand64() % p, rand64() % p, p);
        run_mult("overflow_near_p", p - 1, p - 2, p);
    endtask

    task automatic status_flow();
        logic [`MM_WIDTH-1:0]      a;
        logic [`MM_WIDTH-1:0]      b;
        logic [`MM_WIDTH-1:0]      p;
        logic [`MM_WIDTH-1:0]      r;
        logic [`MM_AXI_DATA_W-1:0] st;
        p = rand64() | `MM_WIDTH'(1);
        a = rand64() % p;
        b = rand64() % p;
        load_operands(a, b, p);
        axi_write(`MM_REG_CTRL, 32'h1);
        axi_read(`MM_REG_STATUS, st);
        check("busy_after_start", 1, st[0]);
        check("done_after_start", 0, st[1]);
        wait_done();
        repeat (2) begin
            axi_read(`MM_REG_STATUS, st);
            check("done_held", 2'b10, st[1:0]);
            read_wide(`MM_REG_R, r);
            check("r_stable", mont_model(a, b, p), r);
        end
    endtask

    task automatic start_while_busy();
        logic [`MM_WIDTH-1:0] a;
        logic [`MM_WIDTH-1:0] b;
        logic [`MM_WIDTH-1:0] p;
        logic [`MM_WIDTH-1:0] r;
        logic [`MM_WIDTH-1:0] b_new;
        p     = rand64() | `MM_WIDTH'(1);
        a     = rand64() % p;
        b     = rand64() % p;
        b_new = rand64() % p;
        load_operands(a, b, p);
        axi_write(`MM_REG_CTRL, 32'h1);
        // New B low word and a second start land mid-run
        axi_write(`MM_REG_B, b_new[31:0]);
        axi_write(`MM_REG_CTRL, 32'h1);
        axi_write(`MM_REG_B + 8'h04, b_new[63:32]);
        wait_done();
        read_wide(`MM_REG_R, r);
        check("start_while_busy", mont_model(a, b, p), r);
    endtask

    task automatic response_back_pressure();
        logic [`MM_WIDTH-1:0] p;
        bp_max = 8;
        for (int t = 0; t < 4; t++) begin
            p = rand64() | `MM_WIDTH'(1);
            run_mult("back_pressure", rand64() % p, rand64() % p, p);
        end
        bp_max = 0;
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        reset_n = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = 4'hF;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        void'($urandom(SEED));
        repeat (2) @(negedge clk);
        reset_n = 1'b1;

        check("reset_bvalid", 0, bvalid);
        check("reset_rvalid", 0, rvalid);
        check("reset_awready", 1, awready);
        check("reset_wready", 1, wready);
        check("reset_arready", 1, arready);

        register_access();
        random_mults();
        edge_operands();
        status_flow();
        start_while_busy();
        response_back_pressure();

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+hw
hw/mm_pkg.sv
hw/mm_pe.sv
hw/mm_core.sv
hw/mm_final_sub.sv
hw/mm_axil_regs.sv
hw/mm_top.sv
verif/tb_mm_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the Montgomery multiplier testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_mm_top \
    -f files.f --Mdir obj_dir -o sim_mm

# The log decides the outcome, so a failing run must not stop the script here
./obj_dir/sim_mm > sim.log 2>&1 || true
cat sim.log

if grep -qx "Verification passed" sim.log; then
    exit 0
fi
exit 1
